// File: source/periph_pkg.sv
/*
 * Peripheral subsystem definitions: bus types, address map, PLIC and
 * timer register offsets, and the error response pattern
 */
`default_nettype none

package periph_pkg;

    // Register bus and interrupt types
    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [2:0]  prio_t;
    typedef logic [2:0]  irq_id_t;

    // Interrupt sources: ext lines are ids 1..4, timers follow
    localparam int NumExtIrq  = 4;
    localparam int NumTimers  = 2;
    localparam int NumSources = NumExtIrq + NumTimers;
    localparam int NumTargets = 2;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam reg_addr_t PlicBase  = 12'h000;
    localparam reg_addr_t PlicSize  = 12'h400;
    localparam reg_addr_t TimerBase = 12'h400;
    localparam reg_addr_t TimerSize = 12'h100;

    // PLIC register offsets, relative to PlicBase
    localparam reg_addr_t PrioOffset      = 12'h000;
    localparam reg_addr_t PendingOffset   = 12'h080;
    localparam reg_addr_t EnableOffset    = 12'h100;
    localparam reg_addr_t ThresholdOffset = 12'h200;
    localparam reg_addr_t ClaimOffset     = 12'h204;
    localparam reg_addr_t TargetStride    = 12'h010;

    // Timer k registers start at k * TimerStride
    localparam reg_addr_t TimerStride = 12'h010;

    // Read data returned with every error response
    localparam reg_data_t ErrData = 32'hDEADBEEF;

endpackage

`default_nettype wire

// File: source/reg_decode.sv
/*
 * Register bus decoder: picks the PLIC or timer region, flags unmapped
 * space and returns the registered response one cycle after the request
 */
`timescale 1ns/1ns
`default_nettype none

module reg_decode (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  req_i,
    input  logic                  we_i,
    input  periph_pkg::reg_addr_t addr_i,
    input  periph_pkg::reg_data_t wdata_i,
    output logic                  plic_sel_o,
    output logic                  timer_sel_o,
    output logic                  we_o,
    output periph_pkg::reg_addr_t offset_o,
    output periph_pkg::reg_data_t wdata_o,
    input  periph_pkg::reg_data_t plic_rdata_i,
    input  periph_pkg::reg_data_t timer_rdata_i,
    input  logic                  plic_err_i,
    input  logic                  timer_err_i,
    output logic                  rsp_valid_o,
    output periph_pkg::reg_data_t rdata_o,
    output logic                  err_o
);
    import periph_pkg::*;

    // Windows are powers of two, so a region hit is a masked compare
    localparam reg_addr_t PlicMask  = ~(PlicSize - 12'd1);
    localparam reg_addr_t TimerMask = ~(TimerSize - 12'd1);

    logic       in_plic;
    logic       in_timer;
    reg_data_t  hit_rdata;
    logic       hit_err;
    logic       rsp_valid_q;
    logic       err_q;
    reg_data_t  rdata_q;

    assign in_plic  = (addr_i & PlicMask) == PlicBase;
    assign in_timer = (addr_i & TimerMask) == TimerBase;

    assign plic_sel_o  = req_i & in_plic;
    assign timer_sel_o = req_i & in_timer;
    assign we_o        = we_i;
    assign wdata_o     = wdata_i;
    assign offset_o    = in_timer ? (addr_i - TimerBase) : (addr_i - PlicBase);

    // Answer of the addressed region, or an error outside both
    always_comb begin
        if (in_plic) begin
            hit_rdata = plic_rdata_i;
            hit_err   = plic_err_i;
        end else if (in_timer) begin
            hit_rdata = timer_rdata_i;
            hit_err   = timer_err_i;
        end else begin
            hit_rdata = '0;
            hit_err   = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            rsp_valid_q <= req_i;
            err_q       <= req_i & hit_err;
        end
    end

    // Response payload, only captured on a request
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= hit_err ? ErrData : hit_rdata;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign err_o       = err_q;
    assign rdata_o     = rdata_q;

endmodule

`default_nettype wire

// File: source/plic_gateway.sv
/*
 * PLIC gateways for level-triggered sources: pending and in-service
 * tracking, one bit each per source
 */
`timescale 1ns/1ns
`default_nettype none

module plic_gateway (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [periph_pkg::NumSources-1:0] src_i,
    input  periph_pkg::irq_id_t               claim_i,
    input  periph_pkg::irq_id_t               complete_i,
    output logic [periph_pkg::NumSources-1:0] pending_o
);
    import periph_pkg::*;

    // Bit i belongs to interrupt id i+1
    logic [NumSources-1:0] pending_q;
    logic [NumSources-1:0] in_service_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            for (int i = 0; i < NumSources; i++) begin
                if (claim_i == irq_id_t'(i + 1)) begin
                    pending_q[i]    <= 1'b0;
                    in_service_q[i] <= 1'b1;
                end else if (complete_i == irq_id_t'(i + 1)) begin
                    in_service_q[i] <= 1'b0;
                end else if (src_i[i] && !in_service_q[i]) begin
                    // level seen while idle, stays pending until claimed
                    pending_q[i] <= 1'b1;
                end
            end
        end
    end

    assign pending_o = pending_q;

endmodule

`default_nettype wire

// File: source/plic_core.sv
/*
 * PLIC core: priority, enable and threshold registers, best source per
 * target and the claim/complete handshake with the gateways
 */
`timescale 1ns/1ns
`default_nettype none

module plic_core #(
    parameter int NumTargets = periph_pkg::NumTargets
) (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             sel_i,
    input  logic                             we_i,
    input  periph_pkg::reg_addr_t            offset_i,
    input  periph_pkg::reg_data_t            wdata_i,
    output periph_pkg::reg_data_t            rdata_o,
    output logic                             err_o,
    input  logic [periph_pkg::NumExtIrq-1:0] ext_irq_i,
    input  logic [periph_pkg::NumTimers-1:0] timer_irq_i,
    output logic [NumTargets-1:0]            irq_o
);
    import periph_pkg::*;

    // Source arrays are indexed by id-1
    prio_t                 prio_q [NumSources];
    logic [NumSources-1:0] enable_q [NumTargets];
    prio_t                 threshold_q [NumTargets];

    logic [NumSources-1:0] pending;
    irq_id_t               claim_id [NumTargets];
    irq_id_t               gw_claim;
    irq_id_t               gw_complete;
    logic [NumSources-1:0] prio_wr;
    logic [NumTargets-1:0] enable_wr;
    logic [NumTargets-1:0] threshold_wr;

    plic_gateway i_gateway (
        .clk_i      ( clk_i                    ),
        .reset_i    ( reset_i                  ),
        .src_i      ( {timer_irq_i, ext_irq_i} ),
        .claim_i    ( gw_claim                 ),
        .complete_i ( gw_complete              ),
        .pending_o  ( pending                  )
    );

    // ------------------------------------------------------------------------
    // Best source per target, ties go to the lowest id
    // ------------------------------------------------------------------------
    always_comb begin
        prio_t   best_prio;
        irq_id_t best_id;
        for (int t = 0; t < NumTargets; t++) begin
            best_prio = '0;
            best_id   = '0;
            for (int i = 0; i < NumSources; i++) begin
                if (pending[i] && enable_q[t][i] && (prio_q[i] > best_prio)) begin
                    best_prio = prio_q[i];
                    best_id   = irq_id_t'(i + 1);
                end
            end
            // Only a priority above the threshold may interrupt
            claim_id[t] = (best_prio > threshold_q[t]) ? best_id : '0;
        end
    end

    always_comb begin
        for (int t = 0; t < NumTargets; t++) begin
            irq_o[t] = (claim_id[t] != '0);
        end
    end

    // ------------------------------------------------------------------------
    // Register access
    // ------------------------------------------------------------------------
    always_comb begin
        rdata_o      = '0;
        err_o        = 1'b1;
        prio_wr      = '0;
        enable_wr    = '0;
        threshold_wr = '0;
        gw_claim     = '0;
        gw_complete  = '0;
        for (int i = 0; i < NumSources; i++) begin
            if (offset_i == PrioOffset + reg_addr_t'(4 * (i + 1))) begin
                rdata_o    = reg_data_t'(prio_q[i]);
                err_o      = 1'b0;
                prio_wr[i] = sel_i & we_i;
            end
        end
        // Pending is read only
        if (offset_i == PendingOffset) begin
            rdata_o = reg_data_t'({pending, 1'b0});
            err_o   = we_i;
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (offset_i == EnableOffset + reg_addr_t'(4 * t)) begin
                rdata_o      = reg_data_t'({enable_q[t], 1'b0});
                err_o        = 1'b0;
                enable_wr[t] = sel_i & we_i;
            end
            if (offset_i == ThresholdOffset + reg_addr_t'(TargetStride * t)) begin
                rdata_o         = reg_data_t'(threshold_q[t]);
                err_o           = 1'b0;
                threshold_wr[t] = sel_i & we_i;
            end
            if (offset_i == ClaimOffset + reg_addr_t'(TargetStride * t)) begin
                rdata_o = reg_data_t'(claim_id[t]);
                err_o   = 1'b0;
                if (sel_i && we_i) begin
                    gw_complete = wdata_i[$bits(irq_id_t)-1:0];
                end else if (sel_i) begin
                    gw_claim = claim_id[t];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NumSources; i++) begin
                prio_q[i] <= '0;
            end
            for (int t = 0; t < NumTargets; t++) begin
                enable_q[t]    <= '0;
                threshold_q[t] <= '0;
            end
        end else begin
            for (int i = 0; i < NumSources; i++) begin
                if (prio_wr[i]) begin
                    prio_q[i] <= wdata_i[$bits(prio_t)-1:0];
                end
            end
            for (int t = 0; t < NumTargets; t++) begin
                if (enable_wr[t]) begin
                    enable_q[t] <= wdata_i[NumSources:1];
                end
                if (threshold_wr[t]) begin
                    threshold_q[t] <= wdata_i[$bits(prio_t)-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/timer_unit.sv
/*
 * Compare timers: free-running up-counters that wrap on compare match
 * and pulse their interrupt for one cycle
 */
`timescale 1ns/1ns
`default_nettype none

module timer_unit #(
    parameter int NumTimers = periph_pkg::NumTimers
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  sel_i,
    input  logic                  we_i,
    input  periph_pkg::reg_addr_t offset_i,
    input  periph_pkg::reg_data_t wdata_i,
    output periph_pkg::reg_data_t rdata_o,
    output logic                  err_o,
    output logic [NumTimers-1:0]  irq_o
);
    import periph_pkg::*;

    // Per-timer register layout
    localparam reg_addr_t CountOffset   = 12'h000;
    localparam reg_addr_t CtrlOffset    = 12'h004;
    localparam reg_addr_t CompareOffset = 12'h008;

    reg_data_t            count_q [NumTimers];
    reg_data_t            compare_q [NumTimers];
    logic [NumTimers-1:0] enable_q;
    logic [NumTimers-1:0] count_wr;
    logic [NumTimers-1:0] ctrl_wr;
    logic [NumTimers-1:0] compare_wr;
    logic [NumTimers-1:0] match;

    always_comb begin
        rdata_o    = '0;
        err_o      = 1'b1;
        count_wr   = '0;
        ctrl_wr    = '0;
        compare_wr = '0;
        for (int k = 0; k < NumTimers; k++) begin
            if (offset_i == reg_addr_t'(TimerStride * k) + CountOffset) begin
                rdata_o     = count_q[k];
                err_o       = 1'b0;
                count_wr[k] = sel_i & we_i;
            end
            if (offset_i == reg_addr_t'(TimerStride * k) + CtrlOffset) begin
                rdata_o    = reg_data_t'(enable_q[k]);
                err_o      = 1'b0;
                ctrl_wr[k] = sel_i & we_i;
            end
            if (offset_i == reg_addr_t'(TimerStride * k) + CompareOffset) begin
                rdata_o       = compare_q[k];
                err_o         = 1'b0;
                compare_wr[k] = sel_i & we_i;
            end
        end
    end

    // Match is only seen by an enabled timer
    always_comb begin
        for (int k = 0; k < NumTimers; k++) begin
            match[k] = enable_q[k] && (count_q[k] == compare_q[k]);
        end
    end

    assign irq_o = match;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q <= '0;
            for (int k = 0; k < NumTimers; k++) begin
                count_q[k]   <= '0;
                compare_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NumTimers; k++) begin
                if (ctrl_wr[k]) begin
                    enable_q[k] <= wdata_i[0];
                end
                if (compare_wr[k]) begin
                    compare_q[k] <= wdata_i;
                end
                // A bus load wins over counting
                if (count_wr[k]) begin
                    count_q[k] <= wdata_i;
                end else if (match[k]) begin
                    count_q[k] <= '0;
                end else if (enable_q[k]) begin
                    count_q[k] <= count_q[k] + 32'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/periph_top.sv
/*
 * Peripheral subsystem top: register bus decoder, PLIC and compare timers
 */
`timescale 1ns/1ns
`default_nettype none

module periph_top #(
    parameter int NumTargets = periph_pkg::NumTargets,
    parameter int NumTimers  = periph_pkg::NumTimers
) (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             req_i,
    input  logic                             we_i,
    input  periph_pkg::reg_addr_t            addr_i,
    input  periph_pkg::reg_data_t            wdata_i,
    input  logic [periph_pkg::NumExtIrq-1:0] ext_irq_i,
    output logic                             rsp_valid_o,
    output periph_pkg::reg_data_t            rdata_o,
    output logic                             err_o,
    output logic [NumTargets-1:0]            irq_o
);
    import periph_pkg::*;

    // Shared request towards the regions
    logic           plic_sel;
    logic           timer_sel;
    logic           bus_we;
    reg_addr_t      bus_offset;
    reg_data_t      bus_wdata;

    // Region answers
    reg_data_t      plic_rdata;
    logic           plic_err;
    reg_data_t      timer_rdata;
    logic           timer_err;

    logic [NumTimers-1:0] timer_irq;

    reg_decode i_reg_decode (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .req_i         ( req_i       ),
        .we_i          ( we_i        ),
        .addr_i        ( addr_i      ),
        .wdata_i       ( wdata_i     ),
        .plic_sel_o    ( plic_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .we_o          ( bus_we      ),
        .offset_o      ( bus_offset  ),
        .wdata_o       ( bus_wdata   ),
        .plic_rdata_i  ( plic_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .plic_err_i    ( plic_err    ),
        .timer_err_i   ( timer_err   ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rdata_o       ( rdata_o     ),
        .err_o         ( err_o       )
    );

    plic_core #(
        .NumTargets ( NumTargets )
    ) i_plic (
        .clk_i       ( clk_i      ),
        .reset_i     ( reset_i    ),
        .sel_i       ( plic_sel   ),
        .we_i        ( bus_we     ),
        .offset_i    ( bus_offset ),
        .wdata_i     ( bus_wdata  ),
        .rdata_o     ( plic_rdata ),
        .err_o       ( plic_err   ),
        .ext_irq_i   ( ext_irq_i  ),
        .timer_irq_i ( timer_irq  ),
        .irq_o       ( irq_o      )
    );

    timer_unit #(
        .NumTimers ( NumTimers )
    ) i_timer (
        .clk_i    ( clk_i       ),
        .reset_i  ( reset_i     ),
        .sel_i    ( timer_sel   ),
        .we_i     ( bus_we      ),
        .offset_i ( bus_offset  ),
        .wdata_i  ( bus_wdata   ),
        .rdata_o  ( timer_rdata ),
        .err_o    ( timer_err   ),
        .irq_o    ( timer_irq   )
    );

endmodule

`default_nettype wire

// File: tb/periph_props.sv
/*
 * Bus response and interrupt checks, bound to the peripheral top
 */
`timescale 1ns/1ns
`default_nettype none

module periph_props #(
    parameter int NumTargets = periph_pkg::NumTargets
) (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  req_i,
    input logic                  rsp_valid_o,
    input logic                  err_o,
    input logic [NumTargets-1:0] irq_o
);

    // Every strobe is answered on the next cycle
    rsp_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
        req_i |=> rsp_valid_o)
        else $error("rsp_valid_o missing one cycle after req_i");

    // No response without a request one cycle before
    rsp_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o |-> $past(req_i))
        else $error("rsp_valid_o without a request");

    err_with_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
        err_o |-> rsp_valid_o)
        else $error("err_o outside a response");

    irq_low_in_reset: assert property (@(posedge clk_i)
        reset_i |=> (irq_o == '0))
        else $error("irq_o not low during reset");

endmodule

bind periph_top periph_props #(
    .NumTargets ( NumTargets )
) u_props (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .req_i       ( req_i       ),
    .rsp_valid_o ( rsp_valid_o ),
    .err_o       ( err_o       ),
    .irq_o       ( irq_o       )
);

`default_nettype wire

// File: tb/tb_periph.sv
/*
 * Testbench for the peripheral subsystem: register access, error
 * responses, PLIC claim/complete and the timer 0 interrupt
 */
`timescale 1ns/1ns
`default_nettype none

module tb_periph;
    import periph_pkg::*;

    // Timer register layout and fixed addresses
    localparam reg_addr_t CountReg    = 12'h000;
    localparam reg_addr_t CtrlReg     = 12'h004;
    localparam reg_addr_t CompareReg  = 12'h008;
    localparam reg_addr_t PendingAddr = PlicBase + PendingOffset;
    localparam reg_addr_t NoRegion    = 12'h800;

    // Limit with a wide margin over the length of the full run
    localparam int MaxCycles = 4000;

    logic                  clk_i;
    logic                  reset_i;
    logic                  req_i;
    logic                  we_i;
    reg_addr_t             addr_i;
    reg_data_t             wdata_i;
    logic [NumExtIrq-1:0]  ext_irq_i;
    logic                  rsp_valid_o;
    reg_data_t             rdata_o;
    logic                  err_o;
    logic [NumTargets-1:0] irq_o;

    // Programmed priorities indexed by source id
    prio_t       prio_m [1:NumSources];
    int unsigned cycles = 0;

    periph_top #(
        .NumTargets ( NumTargets ),
        .NumTimers  ( NumTimers  )
    ) u_dut (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .req_i       ( req_i       ),
        .we_i        ( we_i        ),
        .addr_i      ( addr_i      ),
        .wdata_i     ( wdata_i     ),
        .ext_irq_i   ( ext_irq_i   ),
        .rsp_valid_o ( rsp_valid_o ),
        .rdata_o     ( rdata_o     ),
        .err_o       ( err_o       ),
        .irq_o       ( irq_o       )
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == MaxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
            abort_run();
        end
    end

    // ------------------------------------------------------------------------
    // Checks and bus access
    // ------------------------------------------------------------------------
    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input reg_data_t got, input reg_data_t exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_at_most(input string name, input reg_data_t got, input reg_data_t lim);
        assert (got <= lim) else begin
            $display("** Error: %s = 0x%h, above limit 0x%h", name, got, lim);
            abort_run();
        end
    endtask

    task automatic bus_access(input logic we, input reg_addr_t addr, input reg_data_t data,
                              output reg_data_t rdata, output logic err);
        @(negedge clk_i);
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        wdata_i = data;
        @(negedge clk_i);
        req_i = 1'b0;
        we_i  = 1'b0;
        // Response is due exactly one cycle after the strobe
        check_value($sformatf("rsp_valid_o @0x%h", addr), reg_data_t'(rsp_valid_o), 32'd1);
        rdata = rdata_o;
        err   = err_o;
    endtask

    task automatic bus_write(input reg_addr_t addr, input reg_data_t data, input logic exp_err);
        reg_data_t rdata;
        logic      err;
        bus_access(1'b1, addr, data, rdata, err);
        check_value($sformatf("err_o @0x%h", addr), reg_data_t'(err), reg_data_t'(exp_err));
        if (exp_err) begin
            check_value($sformatf("rdata_o @0x%h", addr), rdata, ErrData);
        end
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_data_t data, input logic exp_err);
        logic err;
        bus_access(1'b0, addr, '0, data, err);
        check_value($sformatf("err_o @0x%h", addr), reg_data_t'(err), reg_data_t'(exp_err));
        if (exp_err) begin
            check_value($sformatf("rdata_o @0x%h", addr), data, ErrData);
        end
    endtask

    task automatic read_expect(input reg_addr_t addr, input reg_data_t exp);
        reg_data_t data;
        bus_read(addr, data, 1'b0);
        check_value($sformatf("rdata_o @0x%h", addr), data, exp);
    endtask

    function automatic reg_addr_t prio_addr(input int n);
        return PlicBase + PrioOffset + reg_addr_t'(4 * n);
    endfunction

    function automatic reg_addr_t enable_addr(input int t);
        return PlicBase + EnableOffset + reg_addr_t'(4 * t);
    endfunction

    function automatic reg_addr_t thr_addr(input int t);
        return PlicBase + ThresholdOffset + reg_addr_t'(16 * t);
    endfunction

    function automatic reg_addr_t claim_addr(input int t);
        return PlicBase + ClaimOffset + reg_addr_t'(16 * t);
    endfunction

    function automatic reg_addr_t timer_addr(input int k, input reg_addr_t reg_off);
        return TimerBase + reg_addr_t'(16 * k) + reg_off;
    endfunction

    // Expected claim picks the lowest id among the highest priorities above the threshold
    function automatic irq_id_t pick_source(input logic [NumSources:0] pend,
                                            input logic [NumSources:0] en, input prio_t thr);
        irq_id_t id;
        id = '0;
        for (int p = 1; p <= 7; p++) begin
            if (p > int'(thr)) begin
                for (int n = NumSources; n >= 1; n--) begin
                    if (pend[n] && en[n] && (int'(prio_m[n]) == p)) begin
                        id = irq_id_t'(n);
                    end
                end
            end
        end
        return id;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        reg_data_t             data;
        reg_data_t             val;
        reg_data_t             cmp;
        logic [NumSources:0]   en0;
        logic [NumSources:0]   en1;
        logic [NumSources:0]   pend;
        prio_t                 thr1;
        irq_id_t               first;
        irq_id_t               second;
        logic [NumTargets-1:0] exp_irq;
        int                    mx;

        void'($urandom(32'h52e9));
        clk_i     = 1'b0;
        reset_i   = 1'b1;
        req_i     = 1'b0;
        we_i      = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        ext_irq_i = '0;
        for (int n = 1; n <= NumSources; n++) begin
            prio_m[n] = '0;
        end
        repeat (5) @(negedge clk_i);
        reset_i = 1'b0;

        // Reset values
        check_value("irq_o", reg_data_t'(irq_o), '0);
        for (int n = 1; n <= NumSources; n++) begin
            read_expect(prio_addr(n), '0);
        end
        read_expect(PendingAddr, '0);
        for (int t = 0; t < NumTargets; t++) begin
            read_expect(enable_addr(t), '0);
            read_expect(thr_addr(t), '0);
            read_expect(claim_addr(t), '0);
        end
        for (int k = 0; k < NumTimers; k++) begin
            read_expect(timer_addr(k, CountReg), '0);
            read_expect(timer_addr(k, CtrlReg), '0);
            read_expect(timer_addr(k, CompareReg), '0);
        end

        // Random writes read back masked to the field widths
        for (int n = 1; n <= NumSources; n++) begin
            val = $urandom;
            bus_write(prio_addr(n), val, 1'b0);
            read_expect(prio_addr(n), val & 32'h7);
        end
        for (int t = 0; t < NumTargets; t++) begin
            val = $urandom;
            bus_write(enable_addr(t), val, 1'b0);
            read_expect(enable_addr(t), val & 32'h7E);
            val = $urandom;
            bus_write(thr_addr(t), val, 1'b0);
            read_expect(thr_addr(t), val & 32'h7);
        end
        for (int k = 0; k < NumTimers; k++) begin
            val = $urandom;
            bus_write(timer_addr(k, CompareReg), val, 1'b0);
            read_expect(timer_addr(k, CompareReg), val);
        end

        // Error responses leave the registers alone
        bus_write(prio_addr(1), 32'h5, 1'b0);
        bus_read(NoRegion, data, 1'b1);
        bus_write(NoRegion + prio_addr(1), 32'h2, 1'b1);
        bus_write(PendingAddr, 32'h7E, 1'b1);
        bus_write(timer_addr(0, 12'h00C), $urandom, 1'b1);
        read_expect(prio_addr(1), 32'h5);
        read_expect(PendingAddr, '0);

        // ------------------------------------------------------------------------
        // External interrupts, claim order and complete
        // ------------------------------------------------------------------------
        for (int n = 1; n <= NumSources; n++) begin
            prio_m[n] = (n <= NumExtIrq) ? prio_t'(1 + $urandom % 7) : '0;
            bus_write(prio_addr(n), reg_data_t'(prio_m[n]), 1'b0);
        end
        en0  = 7'b0011110;
        en1  = {2'b00, 4'($urandom), 1'b0};
        thr1 = prio_t'($urandom);
        bus_write(enable_addr(0), reg_data_t'(en0), 1'b0);
        bus_write(enable_addr(1), reg_data_t'(en1), 1'b0);
        bus_write(thr_addr(0), '0, 1'b0);
        bus_write(thr_addr(1), reg_data_t'(thr1), 1'b0);
        @(negedge clk_i);
        ext_irq_i = 4'hF;
        @(negedge clk_i);
        pend       = 7'b0011110;
        exp_irq[0] = (pick_source(pend, en0, '0) != '0);
        exp_irq[1] = (pick_source(pend, en1, thr1) != '0);
        check_value("irq_o", reg_data_t'(irq_o), reg_data_t'(exp_irq));

        first = pick_source(pend, en0, '0);
        read_expect(claim_addr(0), reg_data_t'(first));
        pend[first] = 1'b0;
        second = pick_source(pend, en0, '0);
        read_expect(claim_addr(0), reg_data_t'(second));
        pend[second] = 1'b0;
        read_expect(PendingAddr, reg_data_t'(pend));

        // Line still high, so the completed source comes back
        bus_write(claim_addr(0), reg_data_t'(first), 1'b0);
        pend[first] = 1'b1;
        read_expect(PendingAddr, reg_data_t'(pend));

        // Drain everything left on target 0
        @(negedge clk_i);
        ext_irq_i = '0;
        bus_write(claim_addr(0), reg_data_t'(second), 1'b0);
        for (int i = 0; i < NumSources; i++) begin
            bus_read(claim_addr(0), data, 1'b0);
            if (data != '0) begin
                bus_write(claim_addr(0), data, 1'b0);
            end
        end
        read_expect(PendingAddr, '0);
        check_value("irq_o", reg_data_t'(irq_o), '0);

        // ------------------------------------------------------------------------
        // Timer 0 interrupt on target 1
        // ------------------------------------------------------------------------
        prio_m[5] = prio_t'(1 + $urandom % 7);
        bus_write(prio_addr(5), reg_data_t'(prio_m[5]), 1'b0);
        en1 = 7'b0100000;
        bus_write(enable_addr(1), reg_data_t'(en1), 1'b0);
        bus_write(thr_addr(1), '0, 1'b0);
        cmp = 32'd8 + ($urandom % 32);
        bus_write(timer_addr(0, CountReg), '0, 1'b0);
        bus_write(timer_addr(0, CompareReg), cmp, 1'b0);
        bus_write(timer_addr(0, CtrlReg), 32'd1, 1'b0);
        while (!irq_o[1]) begin
            bus_read(timer_addr(0, CountReg), data, 1'b0);
            check_at_most("timer 0 count", data, cmp);
        end
        read_expect(claim_addr(1), 32'd5);
        // Reads across a full period see the count wrap at the compare value
        repeat (cmp) begin
            bus_read(timer_addr(0, CountReg), data, 1'b0);
            check_at_most("timer 0 count", data, cmp);
        end
        bus_write(timer_addr(0, CtrlReg), '0, 1'b0);
        bus_write(claim_addr(1), 32'd5, 1'b0);

        // Threshold at or above every pending priority masks the target
        prio_m[1] = prio_t'(1 + $urandom % 6);
        prio_m[2] = prio_t'(1 + $urandom % 6);
        bus_write(prio_addr(1), reg_data_t'(prio_m[1]), 1'b0);
        bus_write(prio_addr(2), reg_data_t'(prio_m[2]), 1'b0);
        mx = (prio_m[1] > prio_m[2]) ? int'(prio_m[1]) : int'(prio_m[2]);
        bus_write(thr_addr(0), reg_data_t'(mx) + ($urandom % reg_data_t'(8 - mx)), 1'b0);
        bus_write(enable_addr(0), 32'h6, 1'b0);
        @(negedge clk_i);
        ext_irq_i = 4'b0011;
        repeat (2) @(negedge clk_i);
        check_value("irq_o", reg_data_t'(irq_o), '0);
        read_expect(claim_addr(0), '0);
        read_expect(PendingAddr, 32'h6);
        check_value("irq_o", reg_data_t'(irq_o), '0);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/periph_pkg.sv
source/reg_decode.sv
source/plic_gateway.sv
source/plic_core.sv
source/timer_unit.sv
source/periph_top.sv
tb/periph_props.sv
tb/tb_periph.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_periph
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
